// ==== include/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// data and address width
`define SOC_XLEN 64

// one enable bit per byte lane
`define SOC_MASK_W 8

// core-local timer window, everything else maps to RAM
`define SOC_CLINT_BASE 64'h0000_0000_0200_0000
`define SOC_CLINT_SIZE 64'h0000_0000_0001_0000

// timer registers inside the window
`define SOC_MTIMECMP_ADDR 64'h0000_0000_0200_4000
`define SOC_MTIME_ADDR 64'h0000_0000_0200_bff8

`endif

// ==== src/soc_pkg.sv ====
`include "soc_macros.svh"

package soc_pkg;

    // requester side, enable held until finish
    typedef struct packed {
        logic                     rd_en;
        logic                     wr_en;
        logic [`SOC_XLEN-1:0]     addr;
        logic [`SOC_XLEN-1:0]     wdata;
        logic [`SOC_MASK_W-1:0]   mask;
    } mem_req_t;

    // finish is a single-cycle pulse
    typedef struct packed {
        logic                     finish;
        logic [`SOC_XLEN-1:0]     rdata;
    } mem_rsp_t;

    // strobes toward the external RAM
    typedef struct packed {
        logic                     rd_en;
        logic                     wr_en;
        logic [`SOC_XLEN-1:0]     addr;
        logic [`SOC_XLEN-1:0]     wdata;
        logic [`SOC_MASK_W-1:0]   mask;
    } ram_port_t;

    // where a routed access goes
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_CLINT
    } bus_target_e;

endpackage

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter import soc_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  mem_req_t i_fetch_req,
    input  mem_req_t i_data_req,
    input  mem_req_t i_mmio_req,
    output mem_rsp_t o_fetch_rsp,
    output mem_rsp_t o_data_rsp,
    output mem_rsp_t o_mmio_rsp,
    output mem_req_t o_bus_req,
    input  mem_rsp_t i_bus_rsp
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_DATA,
        GNT_MMIO,
        GNT_FETCH
    } grant_e;

    grant_e   grant_q;
    grant_e   grant_next;
    logic     start_q;
    logic     data_pend;
    logic     mmio_pend;
    logic     fetch_pend;
    mem_req_t sel_req;

    // the current owner still holds enable in its finish cycle
    assign data_pend  = (i_data_req.rd_en | i_data_req.wr_en) && (grant_q != GNT_DATA);
    assign mmio_pend  = (i_mmio_req.rd_en | i_mmio_req.wr_en) && (grant_q != GNT_MMIO);
    assign fetch_pend = i_fetch_req.rd_en && (grant_q != GNT_FETCH);

    always_comb begin
        grant_next = grant_q;
        if (grant_q == GNT_IDLE || i_bus_rsp.finish) begin
            // fixed priority: data, mmio, fetch
            if (data_pend)
                grant_next = GNT_DATA;
            else if (mmio_pend)
                grant_next = GNT_MMIO;
            else if (fetch_pend)
                grant_next = GNT_FETCH;
            else
                grant_next = GNT_IDLE;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant_q <= GNT_IDLE;
            start_q <= 1'b0;
        end else begin
            grant_q <= grant_next;
            start_q <= (grant_next != GNT_IDLE) && (grant_next != grant_q);
        end
    end

    always_comb begin
        case (grant_q)
            GNT_DATA:  sel_req = i_data_req;
            GNT_MMIO:  sel_req = i_mmio_req;
            GNT_FETCH: sel_req = i_fetch_req;
            default:   sel_req = '0;
        endcase
        o_bus_req       = sel_req;
        // enables reach the router only in the first granted cycle
        o_bus_req.rd_en = sel_req.rd_en & start_q;
        o_bus_req.wr_en = sel_req.wr_en & start_q;
    end

    assign o_data_rsp  = '{finish: i_bus_rsp.finish && (grant_q == GNT_DATA),
                           rdata:  i_bus_rsp.rdata};
    assign o_mmio_rsp  = '{finish: i_bus_rsp.finish && (grant_q == GNT_MMIO),
                           rdata:  i_bus_rsp.rdata};
    assign o_fetch_rsp = '{finish: i_bus_rsp.finish && (grant_q == GNT_FETCH),
                           rdata:  i_bus_rsp.rdata};

endmodule

// ==== src/bus_router.sv ====
`timescale 1ns/1ns
`include "soc_macros.svh"

module bus_router import soc_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  mem_req_t i_bus_req,
    output mem_rsp_t o_bus_rsp,
    output mem_req_t o_ram_req,
    input  mem_rsp_t i_ram_rsp,
    output mem_req_t o_clint_req,
    input  mem_rsp_t i_clint_rsp
);

    logic        start;
    logic        clint_hit;
    bus_target_e target_q;

    assign start     = i_bus_req.rd_en | i_bus_req.wr_en;
    assign clint_hit = (i_bus_req.addr >= `SOC_CLINT_BASE) &&
                       (i_bus_req.addr <  `SOC_CLINT_BASE + `SOC_CLINT_SIZE);

    // start goes out in the grant cycle, only toward the decoded target
    always_comb begin
        o_ram_req         = i_bus_req;
        o_ram_req.rd_en   = i_bus_req.rd_en & ~clint_hit;
        o_ram_req.wr_en   = i_bus_req.wr_en & ~clint_hit;
        o_clint_req       = i_bus_req;
        o_clint_req.rd_en = i_bus_req.rd_en & clint_hit;
        o_clint_req.wr_en = i_bus_req.wr_en & clint_hit;
    end

    // target held until the access finishes
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            target_q <= TGT_NONE;
        end else if (start) begin
            target_q <= clint_hit ? TGT_CLINT : TGT_RAM;
        end else if (o_bus_rsp.finish) begin
            target_q <= TGT_NONE;
        end
    end

    always_comb begin
        case (target_q)
            TGT_RAM:   o_bus_rsp = i_ram_rsp;
            TGT_CLINT: o_bus_rsp = i_clint_rsp;
            default:   o_bus_rsp = '0;
        endcase
    end

endmodule

// ==== src/ram_bridge.sv ====
`timescale 1ns/1ns
`include "soc_macros.svh"

module ram_bridge import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  mem_req_t             i_req,
    output mem_rsp_t             o_rsp,
    output ram_port_t            o_ram,
    input  logic [`SOC_XLEN-1:0] i_ram_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_CAPTURE
    } bridge_state_e;

    bridge_state_e            state_q;
    logic                     rd_q;
    logic                     wr_q;
    logic                     finish_q;
    logic [`SOC_XLEN-1:0]     addr_q;
    logic [`SOC_XLEN-1:0]     wdata_q;
    logic [`SOC_MASK_W-1:0]   mask_q;
    logic [`SOC_XLEN-1:0]     rdata_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= ST_IDLE;
            rd_q     <= 1'b0;
            wr_q     <= 1'b0;
            finish_q <= 1'b0;
        end else begin
            rd_q     <= 1'b0;
            wr_q     <= 1'b0;
            finish_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (i_req.rd_en | i_req.wr_en) begin
                        rd_q    <= i_req.rd_en;
                        wr_q    <= i_req.wr_en;
                        state_q <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    // writes are done once the strobe has gone out
                    finish_q <= wr_q;
                    state_q  <= wr_q ? ST_IDLE : ST_CAPTURE;
                end
                default: begin
                    finish_q <= 1'b1;
                    state_q  <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            addr_q  <= i_req.addr;
            wdata_q <= i_req.wdata;
            mask_q  <= i_req.mask;
        end
        // RAM data is valid the cycle after the read strobe
        if (state_q == ST_CAPTURE)
            rdata_q <= i_ram_rdata;
    end

    assign o_ram = '{rd_en: rd_q, wr_en: wr_q, addr: addr_q, wdata: wdata_q, mask: mask_q};
    assign o_rsp = '{finish: finish_q, rdata: rdata_q};

endmodule

// ==== src/clint.sv ====
`timescale 1ns/1ns
`include "soc_macros.svh"

module clint import soc_pkg::*; (
    input  logic     clk,
    input  logic     i_rst_n,
    input  mem_req_t i_req,
    output mem_rsp_t o_rsp,
    output logic     o_timer_intr
);

    logic [`SOC_XLEN-1:0] mtime_q;
    logic [`SOC_XLEN-1:0] mtimecmp_q;
    logic [`SOC_XLEN-1:0] rdata_q;
    logic [`SOC_XLEN-1:0] rd_mux;
    logic                 finish_q;
    logic                 intr_q;
    logic                 wr_mtime;
    logic                 wr_mtimecmp;

    // replace only the bytes enabled in the mask
    function automatic logic [`SOC_XLEN-1:0] merge_bytes(
        input logic [`SOC_XLEN-1:0]   old_val,
        input logic [`SOC_XLEN-1:0]   new_val,
        input logic [`SOC_MASK_W-1:0] mask
    );
        logic [`SOC_XLEN-1:0] res;
        res = old_val;
        for (int b = 0; b < `SOC_MASK_W; b++) begin
            if (mask[b])
                res[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return res;
    endfunction

    assign wr_mtime    = i_req.wr_en && (i_req.addr == `SOC_MTIME_ADDR);
    assign wr_mtimecmp = i_req.wr_en && (i_req.addr == `SOC_MTIMECMP_ADDR);

    always_comb begin
        case (i_req.addr)
            `SOC_MTIME_ADDR:    rd_mux = mtime_q;
            `SOC_MTIMECMP_ADDR: rd_mux = mtimecmp_q;
            default:            rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            finish_q   <= 1'b0;
            intr_q     <= 1'b0;
        end else begin
            finish_q <= i_req.rd_en | i_req.wr_en;
            intr_q   <= (mtime_q >= mtimecmp_q);
            // a software write wins over the tick
            if (wr_mtime)
                mtime_q <= merge_bytes(mtime_q, i_req.wdata, i_req.mask);
            else
                mtime_q <= mtime_q + 1'b1;
            if (wr_mtimecmp)
                mtimecmp_q <= merge_bytes(mtimecmp_q, i_req.wdata, i_req.mask);
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.rd_en)
            rdata_q <= rd_mux;
    end

    assign o_rsp        = '{finish: finish_q, rdata: rdata_q};
    assign o_timer_intr = intr_q;

endmodule

// ==== src/soc_mem_top.sv ====
`timescale 1ns/1ns
`include "soc_macros.svh"

module soc_mem_top import soc_pkg::*; (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  mem_req_t             i_fetch_req,
    input  mem_req_t             i_data_req,
    input  mem_req_t             i_mmio_req,
    output mem_rsp_t             o_fetch_rsp,
    output mem_rsp_t             o_data_rsp,
    output mem_rsp_t             o_mmio_rsp,
    output ram_port_t            o_ram,
    input  logic [`SOC_XLEN-1:0] i_ram_rdata,
    output logic                 o_timer_intr
);

    mem_req_t bus_req;
    mem_rsp_t bus_rsp;
    mem_req_t ram_req;
    mem_rsp_t ram_rsp;
    mem_req_t clint_req;
    mem_rsp_t clint_rsp;

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_fetch_req (i_fetch_req),
        .i_data_req  (i_data_req),
        .i_mmio_req  (i_mmio_req),
        .o_fetch_rsp (o_fetch_rsp),
        .o_data_rsp  (o_data_rsp),
        .o_mmio_rsp  (o_mmio_rsp),
        .o_bus_req   (bus_req),
        .i_bus_rsp   (bus_rsp)
    );

    bus_router i_bus_router (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_bus_req   (bus_req),
        .o_bus_rsp   (bus_rsp),
        .o_ram_req   (ram_req),
        .i_ram_rsp   (ram_rsp),
        .o_clint_req (clint_req),
        .i_clint_rsp (clint_rsp)
    );

    ram_bridge i_ram_bridge (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (ram_req),
        .o_rsp       (ram_rsp),
        .o_ram       (o_ram),
        .i_ram_rdata (i_ram_rdata)
    );

    clint i_clint (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req        (clint_req),
        .o_rsp        (clint_rsp),
        .o_timer_intr (o_timer_intr)
    );

endmodule

// ==== verification/tb_soc_mem.sv ====
`timescale 1ns/1ns
`include "soc_macros.svh"

module tb_soc_mem import soc_pkg::*; ();

    logic                 clk = 1'b0;
    logic                 rst_n;
    mem_req_t             fetch_req;
    mem_req_t             data_req;
    mem_req_t             mmio_req;
    mem_rsp_t             fetch_rsp;
    mem_rsp_t             data_rsp;
    mem_rsp_t             mmio_rsp;
    ram_port_t            ram;
    logic [`SOC_XLEN-1:0] ram_rdata = '0;
    logic                 timer_intr;

    // what the DUT wrote, and what the requests should have left behind
    logic [`SOC_XLEN-1:0] ram_mem [logic [`SOC_XLEN-1:0]];
    logic [`SOC_XLEN-1:0] shadow [logic [`SOC_XLEN-1:0]];
    logic [`SOC_XLEN-1:0] last_ram_addr = '0;
    logic [15:0]          lfsr = 16'd25748;
    int                   ram_strobes = 0;
    int                   cycles = 0;
    int                   max_cycles = 0;
    bit                   test_ok;

    soc_mem_top i_soc_mem_top (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .i_fetch_req  (fetch_req),
        .i_data_req   (data_req),
        .i_mmio_req   (mmio_req),
        .o_fetch_rsp  (fetch_rsp),
        .o_data_rsp   (data_rsp),
        .o_mmio_rsp   (mmio_rsp),
        .o_ram        (ram),
        .i_ram_rdata  (ram_rdata),
        .o_timer_intr (timer_intr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (max_cycles != 0 && cycles > max_cycles) begin
            $display("timeout: a finish or the timer interrupt never came, stopped at cycle %0d",
                     cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // initial RAM contents, spread over the whole address
    function automatic logic [`SOC_XLEN-1:0] fill_word(input logic [`SOC_XLEN-1:0] a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic logic [`SOC_XLEN-1:0] apply_mask(input logic [`SOC_XLEN-1:0] old_w,
                                                        input logic [`SOC_XLEN-1:0] new_w,
                                                        input logic [`SOC_MASK_W-1:0] m);
        logic [`SOC_XLEN-1:0] lanes;
        for (int b = 0; b < `SOC_MASK_W; b++)
            lanes[b*8 +: 8] = {8{m[b]}};
        return (old_w & ~lanes) | (new_w & lanes);
    endfunction

    function automatic logic [`SOC_XLEN-1:0] ram_word(input logic [`SOC_XLEN-1:0] a);
        return ram_mem.exists(a) ? ram_mem[a] : fill_word(a);
    endfunction

    function automatic logic [`SOC_XLEN-1:0] expected_word(input logic [`SOC_XLEN-1:0] a);
        return shadow.exists(a) ? shadow[a] : fill_word(a);
    endfunction

    function automatic bus_target_e target_of(input logic [`SOC_XLEN-1:0] a);
        if (a >= `SOC_CLINT_BASE && a < `SOC_CLINT_BASE + `SOC_CLINT_SIZE)
            return TGT_CLINT;
        return TGT_RAM;
    endfunction

    // external RAM, read data one cycle after the strobe
    always @(posedge clk) begin
        if (ram.rd_en)
            ram_rdata <= ram_word(ram.addr);
        if (ram.wr_en)
            ram_mem[ram.addr] = apply_mask(ram_word(ram.addr), ram.wdata, ram.mask);
        if (ram.rd_en | ram.wr_en) begin
            ram_strobes++;
            last_ram_addr = ram.addr;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic idle_gap();
        int gap;
        gap = {lfsr_step(), lfsr_step()};
        repeat (gap) @(negedge clk);
    endtask

    function automatic void report_fail(input string name, input string what);
        $display("%s: %s", name, what);
        test_ok = 1'b0;
    endfunction

    function automatic void check_value(input string name, input logic [`SOC_XLEN-1:0] exp,
                                        input logic [`SOC_XLEN-1:0] act);
        assert (act === exp) else begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endfunction

    function automatic mem_req_t make_req(input logic wr, input logic [`SOC_XLEN-1:0] a,
                                          input logic [`SOC_XLEN-1:0] d,
                                          input logic [`SOC_MASK_W-1:0] m);
        return '{rd_en: !wr, wr_en: wr, addr: a, wdata: d, mask: m};
    endfunction

    function automatic void drive_port(input string port, input mem_req_t req);
        if (port == "D")
            data_req = req;
        else if (port == "M")
            mmio_req = req;
        else
            fetch_req = req;
    endfunction

    function automatic mem_rsp_t port_rsp(input string port);
        if (port == "D")
            return data_rsp;
        else if (port == "M")
            return mmio_rsp;
        return fetch_rsp;
    endfunction

    // called on a falling edge, enable held until finish, dropped one cycle later
    task automatic access(input string port, input mem_req_t req,
                          output logic [`SOC_XLEN-1:0] rdata, output int done_cycle);
        mem_rsp_t rsp;
        drive_port(port, req);
        do begin
            @(negedge clk);
            rsp = port_rsp(port);
        end while (!rsp.finish);
        rdata = rsp.rdata;
        done_cycle = cycles;
        @(negedge clk);
        drive_port(port, '0);
    endtask

    task automatic execute(input string name, input string port, input string op,
                           input logic [`SOC_XLEN-1:0] addr, input logic [`SOC_XLEN-1:0] data,
                           input logic [`SOC_MASK_W-1:0] mask,
                           input logic [`SOC_XLEN-1:0] exp);
        logic [`SOC_XLEN-1:0] got;
        logic [`SOC_XLEN-1:0] got2;
        logic [`SOC_XLEN-1:0] cmp;
        int                   t_a;
        int                   t_b;
        int                   strobes0;
        strobes0 = ram_strobes;
        if (op == "Z") begin
            assert (!(fetch_rsp.finish | data_rsp.finish | mmio_rsp.finish |
                      ram.rd_en | ram.wr_en | timer_intr))
                else report_fail(name, "an output is not idle after reset");
        end else if (op == "W") begin
            access(port, make_req(1'b1, addr, data, mask), got, t_a);
            if (target_of(addr) == TGT_RAM)
                shadow[addr] = apply_mask(expected_word(addr), data, mask);
        end else if (op == "R" || op == "S") begin
            access(port, make_req(1'b0, addr, '0, 8'hff), got, t_a);
            check_value(name, (op == "R") ? exp : expected_word(addr), got);
        end else if (op == "T") begin
            access(port, make_req(1'b0, addr, '0, 8'hff), got, t_a);
            access(port, make_req(1'b0, addr, '0, 8'hff), got2, t_a);
            assert (got2 > got) else report_fail(name, "mtime did not increase between two reads");
        end else if (op == "I") begin
            access(port, make_req(1'b0, `SOC_MTIME_ADDR, '0, 8'hff), got, t_a);
            cmp = got + data;
            access(port, make_req(1'b1, addr, cmp, 8'hff), got2, t_a);
            assert (!timer_intr) else report_fail(name, "timer interrupt high before mtime got there");
            while (!timer_intr)
                @(negedge clk);
            access(port, make_req(1'b0, `SOC_MTIME_ADDR, '0, 8'hff), got2, t_a);
            assert (got2 >= cmp) else report_fail(name, "timer interrupt came while mtime was low");
            access(port, make_req(1'b1, addr, '1, 8'hff), got2, t_a);
            @(negedge clk);
            assert (!timer_intr) else report_fail(name, "timer interrupt stayed high after clearing");
        end else begin
            // data and fetch raise enable on the same edge
            fork
                access("D", make_req(1'b0, addr, '0, 8'hff), got, t_a);
                access("F", make_req(1'b0, data, '0, 8'hff), got2, t_b);
            join
            check_value({name, "/data"}, expected_word(addr), got);
            check_value({name, "/fetch"}, expected_word(data), got2);
            assert (t_a < t_b) else report_fail(name, "data finish did not come before fetch finish");
        end
        if (op != "Z" && target_of(addr) == TGT_CLINT) begin
            assert (ram_strobes == strobes0) else report_fail(name, "RAM strobe on a CLINT access");
        end else if (op != "Z") begin
            assert (ram_strobes == strobes0 + ((op == "C") ? 2 : 1))
                else report_fail(name, "RAM strobe count does not match the accesses");
            assert (op == "C" || last_ram_addr === addr)
                else report_fail(name, "RAM strobe at a different address than the request");
        end
    endtask

    initial begin
        string                tests[$];
        string                line;
        string                name;
        string                port;
        string                op;
        logic [`SOC_XLEN-1:0] addr;
        logic [`SOC_XLEN-1:0] data;
        logic [`SOC_XLEN-1:0] exp;
        logic [`SOC_MASK_W-1:0] mask;
        int                   fd;
        int                   n;
        int                   n_pass;
        int                   n_fail;
        fetch_req = '0;
        data_req  = '0;
        mmio_req  = '0;
        rst_n     = 1'b0;
        n_pass    = 0;
        n_fail    = 0;
        fd = $fopen("verification/soc_patterns.txt", "r");
        if (fd == 0) begin
            $display("pattern file verification/soc_patterns.txt could not be opened");
            $display("Regression failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0 && line.len() > 3 && line.substr(0, 0) != "#")
                    tests.push_back(line);
            end
            $fclose(fd);
            max_cycles = tests.size() * 40 + 200;
            repeat (2) @(negedge clk);
            rst_n = 1'b1;
            foreach (tests[i]) begin
                test_ok = 1'b1;
                n = $sscanf(tests[i], "%s %s %s %h %h %h %h", name, port, op, addr, data, mask,
                            exp);
                if (n == 7)
                    execute(name, port, op, addr, data, mask, exp);
                else
                    report_fail(name, "pattern line could not be parsed");
                $display("%-14s %s", name, test_ok ? "ok" : "FAILED");
                if (test_ok)
                    n_pass++;
                else
                    n_fail++;
                idle_gap();
            end
            $display("tests %0d, passed %0d, failed %0d", tests.size(), n_pass, n_fail);
            if (n_fail == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// ==== compile.f ====
+incdir+include
src/soc_pkg.sv
src/mem_arbiter.sv
src/bus_router.sv
src/ram_bridge.sv
src/clint.sv
src/soc_mem_top.sv
verification/tb_soc_mem.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run from the project root, status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_mem -f compile.f &&
./obj_dir/Vtb_soc_mem | tee /dev/stderr | grep -q "Regression passed" &&
echo "run.sh: simulation ok" ||
{ echo "run.sh: simulation not ok"; exit 1; }

// ==== verification/soc_patterns.txt ====
# name port op addr data mask expected, numbers in hex
# op: Z reset, W write, R read vs expected, S read vs RAM model, T mtime rises, I timer, C contention
reset_state    - Z 0 0 0 0
ram_wr_full    D W 80000000 1122334455667788 ff 0
ram_wr_mask    D W 80000000 aabbccddeeff0011 3c 0
ram_rd_model   D S 80000000 0 ff 0
ram_rd_merged  D R 80000000 0 ff 1122ccddeeff7788
fetch_rd_fill  F S 80000100 0 ff 0
fetch_rd_wr    F S 80000000 0 ff 0
mmio_rd_ram    M S 10000000 0 ff 0
mmio_wr_ram    M W 10000008 0123456789abcdef 81 0
mmio_rd_back   M S 10000008 0 ff 0
cmp_wr_mask    M W 2004000 0000000000001234 0f 0
cmp_rd_back    M R 2004000 0 ff ffffffff00001234
clint_hole_rd  M R 2000010 0 ff 0
mtime_rises    M T 200bff8 0 ff 0
timer_intr     M I 2004000 30 ff 0
contend_rd     D C 80000000 80000100 ff 0
contend_rd2    D C 10000008 80000000 ff 0
